//--- list.f
design/board_pkg.sv
design/sync_signal.sv
design/sync_reset.sv
design/debounce_switch.sv
design/reset_sequencer.sv
design/board_top.sv
sim/board_assertions.sv
sim/tb_board_top.sv

//--- Makefile
# Verilator build and run of the board glue testbench

VERILATOR ?= verilator
FLAGS     := --binary --timing --assert -Wno-fatal
TOP       := tb_board_top
FILELIST  := list.f
OBJ_DIR   := obj_dir
PASS_MSG  := Done: no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Status comes from the search for the pass line in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- sim/tb_board_top.sv
// **************************************************
// Testbench for board_top: clock and reset, release
// timing checks, stimulus table and compare tasks
// **************************************************

`timescale 1ns/1ps

module tb_board_top;

    import board_pkg::*;

    localparam int SYNC_STAGES   = SYNC_STAGES_DEF;
    localparam int RESET_STAGES  = RESET_STAGES_DEF;
    localparam int DEBOUNCE_N    = DEBOUNCE_N_DEF;
    localparam int DEBOUNCE_RATE = 4;

    // Worst gpio latency plus both reset stages and a small margin
    localparam int SETTLE_CYCLES = SYNC_STAGES + (DEBOUNCE_N + 1) * DEBOUNCE_RATE
                                 + 2 * RESET_STAGES + 2;
    localparam int TIMEOUT_CYCLES = 4 * SETTLE_CYCLES;

    localparam logic [QUAD_COUNT-1:0] ALL_DONE = '1;

    // State just after rst_i falls
    localparam reset_ctrl_t RST_IN_RESET = '{gth_reset: 1'b1, core_reset: 1'b1,
        phy_rst_n_left: 1'b0, phy_rst_n_right: 1'b0, clk_mux_rst_n: 1'b0};
    localparam reset_ctrl_t RST_HELD = '{gth_reset: 1'b1, core_reset: 1'b1,
        phy_rst_n_left: 1'b0, phy_rst_n_right: 1'b0, clk_mux_rst_n: 1'b1};
    localparam reset_ctrl_t RST_CORE_HELD = '{gth_reset: 1'b0, core_reset: 1'b1,
        phy_rst_n_left: 1'b0, phy_rst_n_right: 1'b0, clk_mux_rst_n: 1'b1};
    localparam reset_ctrl_t RST_RELEASED = '{gth_reset: 1'b0, core_reset: 1'b0,
        phy_rst_n_left: 1'b1, phy_rst_n_right: 1'b1, clk_mux_rst_n: 1'b1};

    typedef struct {
        string                 name;
        gpio_t                 gpio;
        clk_status_t           lol;
        logic [QUAD_COUNT-1:0] done;
        bit                    pulse_only;
        gpio_t                 exp_gpio;
        reset_ctrl_t           exp_reset;
    } row_t;

    logic                  sys_clk;
    logic                  rst;
    gpio_t                 gpio_in;
    clk_status_t           clk_status;
    logic [QUAD_COUNT-1:0] quad_done;
    gpio_t                 gpio_out;
    reset_ctrl_t           reset_out;

    row_t stim_table [$];
    int   seed = 36927;

    board_top #(
        .SYNC_STAGES   (SYNC_STAGES),
        .RESET_STAGES  (RESET_STAGES),
        .DEBOUNCE_N    (DEBOUNCE_N),
        .DEBOUNCE_RATE (DEBOUNCE_RATE)
    ) dut_i (
        .sys_clk_i         (sys_clk),
        .rst_i             (rst),
        .gpio_i            (gpio_in),
        .clk_status_i      (clk_status),
        .quad_reset_done_i (quad_done),
        .gpio_o            (gpio_out),
        .reset_o           (reset_out)
    );

    always #5 sys_clk = ~sys_clk;

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "simulation stopped on the first failure");
    endtask

    task automatic report_timeout(input string what);
        $display("** Error: timed out waiting for %s", what);
        abort_run();
    endtask

    // Inputs change and outputs are read 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge sys_clk);
        #1;
    endtask

    task automatic check_gpio(input string name, input gpio_t exp, input gpio_t act);
        if (act !== exp) begin
            $display("** Error: %s: expected gpio %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_reset(input string name, input reset_ctrl_t exp,
                               input reset_ctrl_t act);
        if (act !== exp) begin
            $display("** Error: %s: expected reset %b, actual %b", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("** Error: %s: expected %0d cycles, actual %0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic wait_for_reset(input string name, input reset_ctrl_t exp);
        int cycles;
        cycles = 0;
        while (reset_out !== exp) begin
            next_cycle();
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout({name, " reset state"});
            end
        end
    endtask

    // Counts edges from the release until each reset stage drops
    task automatic measure_release(input string name, input int exp_gth);
        int cycles;
        cycles = 0;
        while (reset_out.gth_reset) begin
            next_cycle();
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout({name, " gth_reset release"});
            end
        end
        check_count({name, " gth_reset"}, exp_gth, cycles);
        cycles = 0;
        while (reset_out.core_reset) begin
            next_cycle();
            cycles++;
            if (cycles > TIMEOUT_CYCLES) begin
                report_timeout({name, " core_reset release"});
            end
        end
        check_count({name, " core_reset"}, RESET_STAGES, cycles);
        check_reset({name, " released"}, RST_RELEASED, reset_out);
    endtask

    function automatic row_t make_row(input string name, input gpio_t gpio,
                                      input clk_status_t lol,
                                      input logic [QUAD_COUNT-1:0] done,
                                      input bit pulse_only, input gpio_t exp_gpio,
                                      input reset_ctrl_t exp_reset);
        row_t row;
        row.name       = name;
        row.gpio       = gpio;
        row.lol        = lol;
        row.done       = done;
        row.pulse_only = pulse_only;
        row.exp_gpio   = exp_gpio;
        row.exp_reset  = exp_reset;
        return row;
    endfunction

    task automatic build_table();
        gpio_t base;
        base = '0;
        stim_table.push_back(make_row("quad_gating_hold", base, 2'b00, 6'b111011, 1'b0,
                                      base, RST_CORE_HELD));
        stim_table.push_back(make_row("quad_gating_release", base, 2'b00, ALL_DONE, 1'b0,
                                      base, RST_RELEASED));
        stim_table.push_back(make_row("lol_left_set", base, 2'b10, ALL_DONE, 1'b0,
                                      base, RST_HELD));
        stim_table.push_back(make_row("lol_left_clear", base, 2'b00, ALL_DONE, 1'b0,
                                      base, RST_RELEASED));
        stim_table.push_back(make_row("lol_right_set", base, 2'b01, ALL_DONE, 1'b0,
                                      base, RST_HELD));
        stim_table.push_back(make_row("lol_right_clear", base, 2'b00, ALL_DONE, 1'b0,
                                      base, RST_RELEASED));
        stim_table.push_back(make_row("lol_both_set", base, 2'b11, ALL_DONE, 1'b0,
                                      base, RST_HELD));
        stim_table.push_back(make_row("lol_clear", base, 2'b00, ALL_DONE, 1'b0,
                                      base, RST_RELEASED));
        // Stable switch and jumper values
        for (int i = 0; i < 4; i++) begin
            base = 6'($random(seed));
            stim_table.push_back(make_row($sformatf("stable_%0d", i), base, 2'b00,
                                          ALL_DONE, 1'b0, base, RST_RELEASED));
        end
        // Single-sample pulses around the last stable value
        stim_table.push_back(make_row("glitch_switch", base ^ 6'b100000, 2'b00, ALL_DONE,
                                      1'b1, base, RST_RELEASED));
        stim_table.push_back(make_row("glitch_jumper", base ^ 6'b000001, 2'b00, ALL_DONE,
                                      1'b1, base, RST_RELEASED));
        stim_table.push_back(make_row("glitch_all", base ^ 6'b111111, 2'b00, ALL_DONE,
                                      1'b1, base, RST_RELEASED));
    endtask

    task automatic apply_row(input row_t row);
        int cycles;
        gpio_in    = row.gpio;
        clk_status = row.lol;
        quad_done  = row.done;
        if (row.pulse_only) begin
            // Pulse of DEBOUNCE_RATE edges never moves the output
            for (cycles = 0; cycles < DEBOUNCE_RATE; cycles++) begin
                next_cycle();
                check_gpio(row.name, row.exp_gpio, gpio_out);
            end
            gpio_in = row.exp_gpio;
            for (cycles = 0; cycles < SETTLE_CYCLES; cycles++) begin
                next_cycle();
                check_gpio(row.name, row.exp_gpio, gpio_out);
            end
            check_reset(row.name, row.exp_reset, reset_out);
        end else begin
            cycles = 0;
            while ((gpio_out !== row.exp_gpio || reset_out !== row.exp_reset)
                   && cycles < SETTLE_CYCLES) begin
                next_cycle();
                cycles++;
            end
            check_gpio(row.name, row.exp_gpio, gpio_out);
            check_reset(row.name, row.exp_reset, reset_out);
        end
    endtask

    initial begin
        sys_clk    = 1'b0;
        rst        = 1'b1;
        gpio_in    = '0;
        clk_status = '0;
        quad_done  = ALL_DONE;
        build_table();

        next_cycle();
        next_cycle();
        rst = 1'b0;
        check_reset("reset_state", RST_IN_RESET, reset_out);
        check_gpio("reset_state", '0, gpio_out);

        // Lock synchronizer cleared by reset so only the stretch remains
        measure_release("reset_release", RESET_STAGES);

        clk_status.lol_right = 1'b1;
        wait_for_reset("lol_assert", RST_HELD);
        clk_status = '0;
        measure_release("lol_release", SYNC_STAGES + RESET_STAGES);

        foreach (stim_table[i]) begin
            apply_row(stim_table[i]);
        end
        next_cycle();

        if (dut_i.u_board_assert.fail_count != 0) begin
            $display("** Error: %0d assertion failures", dut_i.u_board_assert.fail_count);
            abort_run();
        end else begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

//--- sim/board_assertions.sv
// **************************************************
// Concurrent checks on the reset outputs and the
// debounced gpio, bound into board_top
// **************************************************

`timescale 1ns/1ps

module board_assertions (
    input logic                   sys_clk_i,
    input logic                   rst_i,
    input board_pkg::reset_ctrl_t reset_i,
    input board_pkg::gpio_t       gpio_i,
    input logic                   tick_i
);

    // Number of failed assertions
    int fail_count = 0;

    // Core stays in reset for at least a cycle after the transceivers
    core_after_gth: assert property (
        @(posedge sys_clk_i) disable iff (rst_i)
        reset_i.gth_reset |=> reset_i.core_reset
    ) else begin
        $error("core_reset low in the cycle after gth_reset was high");
        fail_count++;
    end

    phy_left_follows_core: assert property (
        @(posedge sys_clk_i) disable iff (rst_i)
        reset_i.phy_rst_n_left != reset_i.core_reset
    ) else begin
        $error("phy_rst_n_left is not the inverse of core_reset");
        fail_count++;
    end

    phy_right_follows_core: assert property (
        @(posedge sys_clk_i) disable iff (rst_i)
        reset_i.phy_rst_n_right != reset_i.core_reset
    ) else begin
        $error("phy_rst_n_right is not the inverse of core_reset");
        fail_count++;
    end

    // Debounced value moves only on a sample tick
    gpio_steady_between_ticks: assert property (
        @(posedge sys_clk_i) disable iff (rst_i)
        !tick_i |=> $stable(gpio_i)
    ) else begin
        $error("gpio_o changed without a debounce tick");
        fail_count++;
    end

endmodule

bind board_top board_assertions u_board_assert (
    .sys_clk_i (sys_clk_i),
    .rst_i     (rst_i),
    .reset_i   (reset_o),
    .gpio_i    (gpio_o),
    .tick_i    (u_debounce.sample_tick)
);

//--- design/board_top.sv
// **************************************************
// Board glue top: input synchronizers, switch
// debouncer and reset sequencer
// **************************************************

`timescale 1ns/1ps

module board_top #(
    parameter int SYNC_STAGES   = board_pkg::SYNC_STAGES_DEF,
    parameter int RESET_STAGES  = board_pkg::RESET_STAGES_DEF,
    parameter int DEBOUNCE_N    = board_pkg::DEBOUNCE_N_DEF,
    parameter int DEBOUNCE_RATE = board_pkg::DEBOUNCE_RATE_DEF
) (
    // 50 MHz system clock, synchronous reset
    input  logic                             sys_clk_i,
    input  logic                             rst_i,

    // Raw board inputs
    input  board_pkg::gpio_t                 gpio_i,
    input  board_pkg::clk_status_t           clk_status_i,
    input  logic [board_pkg::QUAD_COUNT-1:0] quad_reset_done_i,

    // Debounced inputs and reset state
    output board_pkg::gpio_t                 gpio_o,
    output board_pkg::reset_ctrl_t           reset_o
);

    import board_pkg::*;

    gpio_t       gpio_sync;
    clk_status_t clk_sync;

    // Switches and jumpers
    sync_signal #(
        .T           (gpio_t),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_gpio_sync (
        .sys_clk_i (sys_clk_i),
        .rst_i     (rst_i),
        .data_i    (gpio_i),
        .data_o    (gpio_sync)
    );

    // Loss-of-lock flags from the clock muxes
    sync_signal #(
        .T           (clk_status_t),
        .SYNC_STAGES (SYNC_STAGES)
    ) u_clk_sync (
        .sys_clk_i (sys_clk_i),
        .rst_i     (rst_i),
        .data_i    (clk_status_i),
        .data_o    (clk_sync)
    );

    debounce_switch #(
        .DEBOUNCE_N    (DEBOUNCE_N),
        .DEBOUNCE_RATE (DEBOUNCE_RATE)
    ) u_debounce (
        .sys_clk_i (sys_clk_i),
        .rst_i     (rst_i),
        .gpio_i    (gpio_sync),
        .gpio_o    (gpio_o)
    );

    // Reset done flags are already in the system clock domain
    reset_sequencer #(
        .RESET_STAGES (RESET_STAGES)
    ) u_reset_seq (
        .sys_clk_i         (sys_clk_i),
        .rst_i             (rst_i),
        .clk_status_i      (clk_sync),
        .quad_reset_done_i (quad_reset_done_i),
        .reset_o           (reset_o)
    );

endmodule

//--- design/reset_sequencer.sv
// **************************************************
// Transceiver and core reset chain, PHY and
// clock-mux reset pins
// **************************************************

`timescale 1ns/1ps

module reset_sequencer #(
    parameter int RESET_STAGES = 6
) (
    input  logic                           sys_clk_i,
    input  logic                           rst_i,
    input  board_pkg::clk_status_t         clk_status_i,
    input  logic [board_pkg::QUAD_COUNT-1:0] quad_reset_done_i,
    output board_pkg::reset_ctrl_t         reset_o
);

    import board_pkg::*;

    logic        lock_lost;
    logic        all_quads_done;
    logic        gth_req;
    logic        core_req;
    logic        gth_reset;
    logic        core_reset;
    logic        clk_mux_rst_n_q;
    reset_ctrl_t ctrl;

    // Either clock mux out of lock invalidates the reference clocks
    assign lock_lost = clk_status_i.lol_left | clk_status_i.lol_right;
    assign all_quads_done = &quad_reset_done_i;

    // Transceiver stage
    assign gth_req = rst_i | lock_lost;

    sync_reset #(
        .RESET_STAGES (RESET_STAGES)
    ) u_gth_reset (
        .sys_clk_i (sys_clk_i),
        .rst_req_i (gth_req),
        .rst_o     (gth_reset)
    );

    // Core waits for the transceivers to be out of reset and every quad done
    assign core_req = gth_reset | ~all_quads_done;

    sync_reset #(
        .RESET_STAGES (RESET_STAGES)
    ) u_core_reset (
        .sys_clk_i (sys_clk_i),
        .rst_req_i (core_req),
        .rst_o     (core_reset)
    );

    // Clock mux is released one cycle after system reset
    always_ff @(posedge sys_clk_i) begin
        clk_mux_rst_n_q <= ~rst_i;
    end

    always_comb begin
        ctrl.gth_reset       = gth_reset;
        ctrl.core_reset      = core_reset;
        // Both PHYs follow the core reset
        ctrl.phy_rst_n_left  = ~core_reset;
        ctrl.phy_rst_n_right = ~core_reset;
        ctrl.clk_mux_rst_n   = clk_mux_rst_n_q;
    end

    assign reset_o = ctrl;

endmodule

//--- design/debounce_switch.sv
// **************************************************
// Sampled history debouncer for switches and jumpers
// **************************************************

`timescale 1ns/1ps

module debounce_switch #(
    parameter int DEBOUNCE_N = 4,
    parameter int DEBOUNCE_RATE = 50000
) (
    input  logic              sys_clk_i,
    input  logic              rst_i,
    input  board_pkg::gpio_t  gpio_i,
    output board_pkg::gpio_t  gpio_o
);

    import board_pkg::*;

    localparam int GPIO_W = $bits(gpio_t);
    localparam int CNT_W = (DEBOUNCE_RATE > 1) ? $clog2(DEBOUNCE_RATE) : 1;

    logic [CNT_W-1:0]      cnt_q;
    logic                  sample_tick;
    logic [GPIO_W-1:0]     in_bits;
    logic [GPIO_W-1:0]     out_q;
    logic [DEBOUNCE_N-1:0] hist_q [GPIO_W];
    logic [DEBOUNCE_N-1:0] hist_next [GPIO_W];

    assign in_bits = gpio_i;

    // Prescaler, one sample tick every DEBOUNCE_RATE clocks
    assign sample_tick = (cnt_q == CNT_W'(DEBOUNCE_RATE - 1));

    // Newest sample enters at bit 0
    always_comb begin
        for (int k = 0; k < GPIO_W; k++) begin
            hist_next[k] = (hist_q[k] << 1) | DEBOUNCE_N'(in_bits[k]);
        end
    end

    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
            out_q <= '0;
            for (int k = 0; k < GPIO_W; k++) begin
                hist_q[k] <= '0;
            end
        end else begin
            if (sample_tick) begin
                cnt_q <= '0;
            end else begin
                cnt_q <= cnt_q + 1'b1;
            end

            // Output only moves on a tick, and only on a unanimous history
            if (sample_tick) begin
                for (int k = 0; k < GPIO_W; k++) begin
                    hist_q[k] <= hist_next[k];
                    if (&hist_next[k]) begin
                        out_q[k] <= 1'b1;
                    end else if (~|hist_next[k]) begin
                        out_q[k] <= 1'b0;
                    end
                end
            end
        end
    end

    assign gpio_o = gpio_t'(out_q);

endmodule

//--- design/sync_reset.sv
// **************************************************
// Reset stretcher, holds rst_o for RESET_STAGES
// cycles after the request is released
// **************************************************

`timescale 1ns/1ps

module sync_reset #(
    parameter int RESET_STAGES = 6
) (
    input  logic sys_clk_i,
    input  logic rst_req_i,
    output logic rst_o
);

    logic [RESET_STAGES-1:0] stretch_q;

    // The request is the reset of this block:
    // it fills the chain with ones, zeros drain in afterwards
    always_ff @(posedge sys_clk_i) begin
        if (rst_req_i) begin
            stretch_q <= '1;
        end else begin
            stretch_q <= stretch_q << 1;
        end
    end

    // MSB drops on the RESET_STAGES-th clean edge
    assign rst_o = stretch_q[RESET_STAGES-1];

endmodule

//--- design/sync_signal.sv
// **************************************************
// Register chain synchronizer for any packed payload
// **************************************************

`timescale 1ns/1ps

module sync_signal #(
    parameter type T = logic,
    parameter int SYNC_STAGES = 2
) (
    input  logic sys_clk_i,
    input  logic rst_i,
    input  T     data_i,
    output T     data_o
);

    // Stage 0 takes the asynchronous input
    T stage_q [SYNC_STAGES];

    always_ff @(posedge sys_clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < SYNC_STAGES; i++) begin
                stage_q[i] <= '0;
            end
        end else begin
            stage_q[0] <= data_i;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    // Last stage is the settled value
    assign data_o = stage_q[SYNC_STAGES-1];

endmodule

//--- design/board_pkg.sv
// **************************************************
// Shared parameters and packed types for the
// board glue: gpio, clock-mux status, reset outputs
// **************************************************

package board_pkg;

    // Transceiver quads on the board
    localparam int QUAD_COUNT = 6;

    // Defaults for the top-level parameters
    localparam int SYNC_STAGES_DEF = 2;
    localparam int RESET_STAGES_DEF = 6;
    localparam int DEBOUNCE_N_DEF = 4;

    // 50 MHz system clock, so one sample per millisecond
    localparam int DEBOUNCE_RATE_DEF = 50000;

    // Switches and jumpers, switches in the upper bits
    typedef struct packed {
        logic [1:0] sw;
        logic [3:0] jp;
    } gpio_t;

    // Loss-of-lock flags of the two clock muxes
    typedef struct packed {
        logic lol_left;
        logic lol_right;
    } clk_status_t;

    // Reset state driven towards the transceivers and the board
    typedef struct packed {
        // Active high
        logic gth_reset;
        logic core_reset;
        // Active low pins
        logic phy_rst_n_left;
        logic phy_rst_n_right;
        logic clk_mux_rst_n;
    } reset_ctrl_t;

endpackage
